// File: machine_mode_pkg.sv
// Machine-mode trap types for RV32 only; APB addresses are byte offsets of 32-bit words
`default_nettype none

package machine_mode_pkg;

  // Synchronous exception codes as stored in mcause when the interrupt bit is clear
  typedef enum logic [30:0] {
    INSN_MAL     = 31'd0,
    INSN_FAULT   = 31'd1,
    ILLEGAL_INSN = 31'd2,
    BREAKPOINT   = 31'd3,
    L_ADDR_MAL   = 31'd4,
    L_FAULT      = 31'd5,
    S_ADDR_MAL   = 31'd6,
    S_FAULT      = 31'd7,
    ENV_CALL_M   = 31'd11
  } ex_code_t;

  // Interrupt codes, which line up with the pending bit positions in mip
  typedef enum logic [30:0] {
    SOFT_INT  = 31'd3,
    TIMER_INT = 31'd7,
    EXT_INT   = 31'd11
  } int_code_t;

  // One cause field, read as an exception or an interrupt code
  typedef union packed {
    ex_code_t  exc; // Valid when the interrupt bit is clear
    int_code_t irq; // Valid when the interrupt bit is set
  } cause_u;

  typedef struct packed {
    logic   interrupt; // Bit 31 of mcause
    cause_u cause;
  } mcause_t;

  // Only the machine interrupt enable and its stacked copy are implemented
  typedef struct packed {
    logic [23:0] res_31_8;
    logic        pie;      // Bit 7, previous ie
    logic [2:0]  res_6_4;
    logic        ie;       // Bit 3, global machine interrupt enable
    logic [2:0]  res_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [19:0] res_31_12;
    logic        meip;      // Bit 11
    logic [2:0]  res_10_8;
    logic        mtip;      // Bit 7
    logic [2:0]  res_6_4;
    logic        msip;      // Bit 3
    logic [2:0]  res_2_0;
  } mip_t;

  typedef struct packed {
    logic [19:0] res_31_12;
    logic        meie;
    logic [2:0]  res_10_8;
    logic        mtie;
    logic [2:0]  res_6_4;
    logic        msie;
    logic [2:0]  res_2_0;
  } mie_t;

  // Per-cycle trap conditions reported by the pipeline
  typedef struct packed {
    logic        timer_int;
    logic        soft_int;
    logic        ext_int;
    logic        fault_l;
    logic        mal_l;
    logic        fault_s;
    logic        mal_s;
    logic        breakpoint;
    logic        env_m;
    logic        illegal_insn;
    logic        fault_insn;
    logic        mal_insn;
    logic        ret;          // Return from trap
    logic [31:0] curr_epc;
    logic [31:0] curr_epc_p4;
    logic [31:0] fault_addr;
  } trap_req_t;

  typedef struct packed {
    mstatus_t mstatus;
    mie_t     mie;
    mip_t     mip;
  } csr_state_t;

  typedef struct packed {
    logic        mstatus_we;
    mstatus_t    mstatus_next;
    logic        mip_we;
    mip_t        mip_next;
    logic        mcause_we;
    mcause_t     mcause_next;
    logic        mepc_we;
    logic [31:0] mepc_next;
    logic        mbadaddr_we;
    logic [31:0] mbadaddr_next;
  } csr_update_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // CSR map on APB
  parameter logic [7:0] MSTATUS_ADDR  = 8'h00;
  parameter logic [7:0] MIE_ADDR      = 8'h04;
  parameter logic [7:0] MTVEC_ADDR    = 8'h08;
  parameter logic [7:0] MEPC_ADDR     = 8'h0C;
  parameter logic [7:0] MCAUSE_ADDR   = 8'h10;
  parameter logic [7:0] MBADADDR_ADDR = 8'h14;
  parameter logic [7:0] MIP_ADDR      = 8'h18;

endpackage

`default_nettype wire

// File: prv_control.sv
// Machine mode only, direct trap mode; intr and all next values are combinational from trap_req
`timescale 1ns/10ps
`default_nettype none

module prv_control import machine_mode_pkg::*; (
  input  trap_req_t   trap_req,
  input  csr_state_t  csr_state,
  output csr_update_t csr_update,
  output logic        intr
);

  ex_code_t  ex_src;
  logic      exception;
  int_code_t int_src;
  logic      interrupt;
  mip_t      pending;   // mip as it will be after this cycle's lines are merged
  logic      take_tmr;
  logic      take_sw;
  logic      take_ext;
  logic      addr_fault;
  logic      epc_plus4;

  // Lines raised this cycle join the bits already pending
  always_comb begin
    pending = csr_state.mip;
    if (trap_req.timer_int) pending.mtip = 1'b1;
    if (trap_req.soft_int)  pending.msip = 1'b1;
    if (trap_req.ext_int)   pending.meip = 1'b1; // External line lands in meip
  end

  assign take_tmr = pending.mtip & csr_state.mie.mtie;
  assign take_sw  = pending.msip & csr_state.mie.msie;
  assign take_ext = pending.meip & csr_state.mie.meie;

  // Enabled interrupts only count while the global enable is set
  assign interrupt = csr_state.mstatus.ie & (take_tmr | take_sw | take_ext);

  always_comb begin
    int_src = SOFT_INT;
    if (take_tmr) begin
      int_src = TIMER_INT; // Timer outranks the other two lines
    end else if (take_sw) begin
      int_src = SOFT_INT;
    end else if (take_ext) begin
      int_src = EXT_INT;
    end
  end

  // Data-side faults come first, then the instruction-side ones
  always_comb begin
    exception = 1'b1;
    ex_src    = INSN_MAL;
    if (trap_req.fault_l) begin
      ex_src = L_FAULT;
    end else if (trap_req.mal_l) begin
      ex_src = L_ADDR_MAL;
    end else if (trap_req.fault_s) begin
      ex_src = S_FAULT;
    end else if (trap_req.mal_s) begin
      ex_src = S_ADDR_MAL;
    end else if (trap_req.breakpoint) begin
      ex_src = BREAKPOINT;
    end else if (trap_req.env_m) begin
      ex_src = ENV_CALL_M;
    end else if (trap_req.illegal_insn) begin
      ex_src = ILLEGAL_INSN;
    end else if (trap_req.fault_insn) begin
      ex_src = INSN_FAULT;
    end else if (trap_req.mal_insn) begin
      ex_src = INSN_MAL;
    end else begin
      exception = 1'b0;
    end
  end

  // Exceptions are taken regardless of the enable bits
  assign intr = exception | interrupt;

  // Breakpoint and ecall resume after the trapping instruction
  assign epc_plus4 = exception & ((ex_src == BREAKPOINT) | (ex_src == ENV_CALL_M));

  assign addr_fault = exception & ((ex_src == L_FAULT) | (ex_src == L_ADDR_MAL) |
                                   (ex_src == S_FAULT) | (ex_src == S_ADDR_MAL) |
                                   (ex_src == INSN_FAULT) | (ex_src == INSN_MAL));

  always_comb begin
    csr_update = '0;

    // mip only changes when a line is raised, so software can clear it otherwise
    csr_update.mip_we   = trap_req.timer_int | trap_req.soft_int | trap_req.ext_int;
    csr_update.mip_next = pending;

    csr_update.mcause_we             = intr;
    csr_update.mcause_next.interrupt = ~exception;
    if (exception) begin
      csr_update.mcause_next.cause.exc = ex_src;
    end else begin
      csr_update.mcause_next.cause.irq = int_src;
    end

    csr_update.mepc_we   = intr;
    csr_update.mepc_next = epc_plus4 ? trap_req.curr_epc_p4 : trap_req.curr_epc;

    csr_update.mbadaddr_we   = addr_fault;
    csr_update.mbadaddr_next = trap_req.fault_addr;

    csr_update.mstatus_we   = intr | trap_req.ret;
    csr_update.mstatus_next = csr_state.mstatus;
    if (intr) begin
      csr_update.mstatus_next.pie = csr_state.mstatus.ie; // Stack the enable on entry
      csr_update.mstatus_next.ie  = 1'b0;
    end else if (trap_req.ret) begin
      csr_update.mstatus_next.ie = csr_state.mstatus.pie;
    end
  end

endmodule

`default_nettype wire

// File: csr_machine.sv
// Seven machine CSRs with WARL masks on software writes; a trap update beats a same-cycle write
`timescale 1ns/10ps
`default_nettype none

module csr_machine import machine_mode_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  csr_update_t       csr_update,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [31:0]       wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [31:0]       rd_data,
  output logic              addr_ok,
  output csr_state_t        csr_state,
  output logic [31:0]       trap_vector
);

  // Writable bits per register, everything else reads as zero
  localparam logic [31:0] MSTATUS_MASK = 32'h0000_0088;
  localparam logic [31:0] MIE_MASK     = 32'h0000_0888;
  localparam logic [31:0] MIP_MASK     = 32'h0000_0888;
  localparam logic [31:0] MTVEC_MASK   = 32'hFFFF_FFFC; // Direct mode, word aligned
  localparam logic [31:0] MEPC_MASK    = 32'hFFFF_FFFC;
  localparam logic [31:0] MCAUSE_MASK  = 32'h8000_000F;
  localparam logic [31:0] MTVEC_RESET  = 32'h0000_0100;

  mstatus_t    mstatus_q;
  mie_t        mie_q;
  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  mcause_t     mcause_q;
  logic [31:0] mbadaddr_q;
  mip_t        mip_q;

  logic sw_mstatus;
  logic sw_mie;
  logic sw_mtvec;
  logic sw_mepc;
  logic sw_mcause;
  logic sw_mbadaddr;
  logic sw_mip;

  // Write strobes per register from the software port
  assign sw_mstatus  = wr_en & (wr_addr == ADDR_W'(MSTATUS_ADDR));
  assign sw_mie      = wr_en & (wr_addr == ADDR_W'(MIE_ADDR));
  assign sw_mtvec    = wr_en & (wr_addr == ADDR_W'(MTVEC_ADDR));
  assign sw_mepc     = wr_en & (wr_addr == ADDR_W'(MEPC_ADDR));
  assign sw_mcause   = wr_en & (wr_addr == ADDR_W'(MCAUSE_ADDR));
  assign sw_mbadaddr = wr_en & (wr_addr == ADDR_W'(MBADADDR_ADDR));
  assign sw_mip      = wr_en & (wr_addr == ADDR_W'(MIP_ADDR));

  // Registers only touched by software
  always_ff @(posedge clk) begin
    if (rst) begin
      mie_q   <= '0;
      mtvec_q <= MTVEC_RESET;
    end else begin
      if (sw_mie)   mie_q   <= mie_t'(wr_data & MIE_MASK);
      if (sw_mtvec) mtvec_q <= wr_data & MTVEC_MASK;
    end
  end

  // Registers shared with the trap path, where the trap update goes first
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mbadaddr_q <= '0;
      mip_q      <= '0;
    end else begin
      if (csr_update.mstatus_we) begin
        mstatus_q <= csr_update.mstatus_next;
      end else if (sw_mstatus) begin
        mstatus_q <= mstatus_t'(wr_data & MSTATUS_MASK);
      end

      if (csr_update.mepc_we) begin
        mepc_q <= csr_update.mepc_next;
      end else if (sw_mepc) begin
        mepc_q <= wr_data & MEPC_MASK;
      end

      if (csr_update.mcause_we) begin
        mcause_q <= csr_update.mcause_next;
      end else if (sw_mcause) begin
        mcause_q <= mcause_t'(wr_data & MCAUSE_MASK);
      end

      if (csr_update.mbadaddr_we) begin
        mbadaddr_q <= csr_update.mbadaddr_next;
      end else if (sw_mbadaddr) begin
        mbadaddr_q <= wr_data;
      end

      if (csr_update.mip_we) begin
        mip_q <= csr_update.mip_next; // A raised line keeps its bit set
      end else if (sw_mip) begin
        mip_q <= mip_t'(wr_data & MIP_MASK);
      end
    end
  end

  // Read mux, which also tells the bus slave whether the address is mapped
  always_comb begin
    addr_ok = 1'b1;
    rd_data = '0;
    case (rd_addr)
      ADDR_W'(MSTATUS_ADDR):  rd_data = mstatus_q;
      ADDR_W'(MIE_ADDR):      rd_data = mie_q;
      ADDR_W'(MTVEC_ADDR):    rd_data = mtvec_q;
      ADDR_W'(MEPC_ADDR):     rd_data = mepc_q;
      ADDR_W'(MCAUSE_ADDR):   rd_data = mcause_q;
      ADDR_W'(MBADADDR_ADDR): rd_data = mbadaddr_q;
      ADDR_W'(MIP_ADDR):      rd_data = mip_q;
      default:                addr_ok = 1'b0; // Holes and misaligned offsets
    endcase
  end

  assign csr_state.mstatus = mstatus_q;
  assign csr_state.mie     = mie_q;
  assign csr_state.mip     = mip_q;
  assign trap_vector       = mtvec_q; // Direct mode, every trap enters here

endmodule

`default_nettype wire

// File: csr_apb_slave.sv
// APB slave without wait states; ADDR_W must be below 32 and higher paddr bits must be zero
`timescale 1ns/10ps
`default_nettype none

module csr_apb_slave import machine_mode_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              rst,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [31:0]       wr_data,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [31:0]       rd_data,
  input  logic              addr_ok
);

  logic setup_q;    // Previous cycle was a setup phase
  logic access;
  logic high_zero;
  logic valid;

  // Remember the setup phase so that only a proper two-phase transfer is accepted
  always_ff @(posedge clk) begin
    if (rst) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= apb_req.psel & ~apb_req.penable;
    end
  end

  assign access    = apb_req.psel & apb_req.penable;
  assign high_zero = (apb_req.paddr[31:ADDR_W] == '0);
  assign valid     = setup_q & high_zero & addr_ok;

  // Both ports of the register block see the bus address directly
  assign rd_addr = apb_req.paddr[ADDR_W-1:0];
  assign wr_addr = apb_req.paddr[ADDR_W-1:0];
  assign wr_data = apb_req.pwdata;

  // Write lands at the edge that closes the access cycle
  assign wr_en = access & apb_req.pwrite & valid;

  always_comb begin
    apb_rsp.pready  = access;          // No wait states
    apb_rsp.pslverr = access & ~valid; // Unmapped or out of sequence
    apb_rsp.prdata  = '0;
    if (access & ~apb_req.pwrite & valid) begin
      apb_rsp.prdata = rd_data;
    end
  end

endmodule

`default_nettype wire

// File: priv_unit_top.sv
// Machine trap unit top; CSRs at APB byte offsets 0x00 to 0x18, mtvec resets to 0x100
`timescale 1ns/10ps
`default_nettype none

module priv_unit_top import machine_mode_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic        clk,
  input  logic        rst,
  input  trap_req_t   trap_req,
  output logic        intr,
  output logic [31:0] trap_vector,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp
);

  csr_state_t        csr_state;
  csr_update_t       csr_update;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [31:0]       wr_data;
  logic [ADDR_W-1:0] rd_addr;
  logic [31:0]       rd_data;
  logic              addr_ok;

  // Trap selection and next CSR values
  prv_control prv_control_i (
    .trap_req   (trap_req),
    .csr_state  (csr_state),
    .csr_update (csr_update),
    .intr       (intr)
  );

  csr_machine #(.ADDR_W(ADDR_W)) csr_machine_i (
    .clk         (clk),
    .rst         (rst),
    .csr_update  (csr_update),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .addr_ok     (addr_ok),
    .csr_state   (csr_state),
    .trap_vector (trap_vector)
  );

  // Software access path
  csr_apb_slave #(.ADDR_W(ADDR_W)) csr_apb_slave_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .addr_ok (addr_ok)
  );

endmodule

`default_nettype wire

// File: tb_priv_unit.sv
// Table-driven testbench for the trap unit; assumes ADDR_W of 5 and an APB access of two cycles
`timescale 1ns/10ps
`default_nettype none

module tb_priv_unit import machine_mode_pkg::*; ();

  localparam logic [1:0] OP_NONE = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_WR   = 2'd2;

  // Flag bits in trap_req_t field order from timer_int down to ret
  localparam logic [12:0] F_TIMER   = 13'h1000;
  localparam logic [12:0] F_EXT     = 13'h0400;
  localparam logic [12:0] F_FAULT_L = 13'h0200;
  localparam logic [12:0] F_FAULT_S = 13'h0080;
  localparam logic [12:0] F_MAL_S   = 13'h0040;
  localparam logic [12:0] F_BP      = 13'h0020;
  localparam logic [12:0] F_ENV     = 13'h0010;
  localparam logic [12:0] F_ILL     = 13'h0008;
  localparam logic [12:0] F_MALINSN = 13'h0002;
  localparam logic [12:0] F_RET     = 13'h0001;

  typedef struct packed {
    logic [1:0]  op;
    logic [7:0]  addr;
    logic [31:0] wdata;
    trap_req_t   trap;
    logic        exp_intr;
    logic [31:0] exp_data; // Only checked on reads
    logic        exp_err;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  trap_req_t   trap_req;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        intr;
  logic [31:0] trap_vector;

  row_t        rows[$];
  string       names[$];
  logic [31:0] m_mstatus = '0; // Model of the three CSRs that decide intr
  logic [31:0] m_mie     = '0;
  logic [31:0] m_mip     = '0;
  int          err_count = 0;
  int          row_errs  = 0;
  int          fail_rows = 0;
  logic        table_ready = 1'b0;

  priv_unit_top #(.ADDR_W(5)) priv_unit_top_i (
    .clk         (clk),
    .rst         (rst),
    .trap_req    (trap_req),
    .intr        (intr),
    .trap_vector (trap_vector),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
  );

  always #20 clk = ~clk; // 40 ns period

  function automatic trap_req_t build_trap(input logic [12:0] flags, input logic [31:0] epc,
                                           input logic [31:0] fa);
    build_trap = trap_req_t'({flags, epc, epc + 32'd4, fa});
  endfunction

  // Appends one row and steps the model so that intr and CSR reads are predicted
  task automatic add_row(input logic [1:0] op, input logic [7:0] addr, input logic [31:0] wdata,
                         input trap_req_t trap, input logic [31:0] exp_data, input string name);
    row_t        r;
    logic [31:0] pend;
    logic        mapped;
    logic        wr;
    logic        exc;
    logic        take_irq;
    mapped   = (addr[1:0] == 2'b00) && (addr <= 8'h18); // Seven word registers from 0x00
    wr       = (op == OP_WR) && mapped;
    pend     = m_mip | {20'b0, trap.ext_int, 3'b0, trap.timer_int, 3'b0, trap.soft_int, 3'b0};
    take_irq = m_mstatus[3] & (|(pend & m_mie));
    exc      = |{trap.fault_l, trap.mal_l, trap.fault_s, trap.mal_s, trap.breakpoint,
                 trap.env_m, trap.illegal_insn, trap.fault_insn, trap.mal_insn};
    r.op       = op;
    r.addr     = addr;
    r.wdata    = wdata;
    r.trap     = trap;
    r.exp_intr = exc | take_irq;
    r.exp_err  = (op != OP_NONE) && !mapped;
    r.exp_data = mapped ? exp_data : 32'h0;
    if (op == OP_RD && addr == MSTATUS_ADDR) r.exp_data = m_mstatus; // Reads see the old value
    if (op == OP_RD && addr == MIE_ADDR)     r.exp_data = m_mie;
    if (op == OP_RD && addr == MIP_ADDR)     r.exp_data = m_mip;
    // A raised line beats a software write to mip
    if (trap.timer_int | trap.soft_int | trap.ext_int) m_mip = pend;
    else if (wr && addr == MIP_ADDR) m_mip = wdata & 32'h0000_0888;
    if (r.exp_intr) m_mstatus = {24'b0, m_mstatus[3], 7'b0}; // pie takes ie and ie drops
    else if (trap.ret) m_mstatus = {24'b0, m_mstatus[7], 3'b0, m_mstatus[7], 3'b0};
    else if (wr && addr == MSTATUS_ADDR) m_mstatus = wdata & 32'h0000_0088;
    if (wr && addr == MIE_ADDR) m_mie = wdata & 32'h0000_0888;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic compare_signal(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h", $time, sig, got, exp);
      row_errs++;
    end
  endtask

  task automatic build_table();
    int          seed;
    trap_req_t   idle;
    logic [31:0] epc_a;
    logic [31:0] fa_a;
    logic [31:0] epc_b;
    logic [31:0] epc_c;
    logic [31:0] fa_c;
    logic [31:0] epc_d;
    seed  = 78900;
    epc_a = $random(seed) & 32'hFFFF_FFFC;
    fa_a  = $random(seed);
    epc_b = $random(seed) & 32'hFFFF_FFFC;
    epc_c = $random(seed) & 32'hFFFF_FFFC;
    fa_c  = $random(seed);
    epc_d = $random(seed) & 32'hFFFF_FFFC;
    idle  = '0;
    add_row(OP_RD, MSTATUS_ADDR, 0, idle, 32'h0, "reset mstatus");
    add_row(OP_RD, MIE_ADDR, 0, idle, 32'h0, "reset mie");
    add_row(OP_RD, MTVEC_ADDR, 0, idle, 32'h100, "reset mtvec");
    add_row(OP_RD, MEPC_ADDR, 0, idle, 32'h0, "reset mepc");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'h0, "reset mcause");
    add_row(OP_RD, MBADADDR_ADDR, 0, idle, 32'h0, "reset mbadaddr");
    add_row(OP_RD, MIP_ADDR, 0, idle, 32'h0, "reset mip");
    add_row(OP_WR, MSTATUS_ADDR, 32'h8, idle, 0, "set mstatus ie");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_FAULT_L | F_MAL_S | F_BP | F_ILL, epc_a, fa_a), 0,
            "several exceptions at once");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'd5, "mcause is load fault");
    add_row(OP_RD, MSTATUS_ADDR, 0, idle, 0, "ie cleared by trap");
    add_row(OP_RD, MEPC_ADDR, 0, idle, epc_a, "mepc is faulting pc");
    add_row(OP_RD, MBADADDR_ADDR, 0, idle, fa_a, "mbadaddr of load fault");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_ENV, epc_b, 32'h0), 0, "ecall");
    add_row(OP_RD, MEPC_ADDR, 0, idle, epc_b + 32'd4, "mepc after ecall");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'd11, "mcause is ecall");
    add_row(OP_RD, MBADADDR_ADDR, 0, idle, fa_a, "mbadaddr kept by ecall");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_FAULT_S, epc_c, fa_c), 0, "store fault");
    add_row(OP_RD, MEPC_ADDR, 0, idle, epc_c, "mepc of store fault");
    add_row(OP_RD, MBADADDR_ADDR, 0, idle, fa_c, "mbadaddr of store fault");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'd7, "mcause is store fault");
    add_row(OP_WR, MIE_ADDR, 32'h80, idle, 0, "enable mtie");
    add_row(OP_WR, MSTATUS_ADDR, 32'h8, idle, 0, "set mstatus ie again");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_TIMER, epc_d, 32'h0), 0, "timer interrupt");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'h8000_0007, "mcause is timer");
    add_row(OP_RD, MIP_ADDR, 0, idle, 0, "mtip pending");
    add_row(OP_WR, MIE_ADDR, 32'h0, idle, 0, "disable all enables");
    add_row(OP_WR, MIP_ADDR, 32'h0, idle, 0, "clear pending bits");
    add_row(OP_WR, MSTATUS_ADDR, 32'h8, idle, 0, "set mstatus ie third time");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_EXT, 32'h0, 32'h0), 0, "masked external line");
    add_row(OP_RD, MIP_ADDR, 0, idle, 0, "meip pending");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_ILL, epc_a, 32'h0), 0, "illegal instruction");
    add_row(OP_RD, MSTATUS_ADDR, 0, idle, 0, "pie holds ie");
    add_row(OP_NONE, 8'h0, 0, build_trap(F_RET, 32'h0, 32'h0), 0, "return from trap");
    add_row(OP_RD, MSTATUS_ADDR, 0, idle, 0, "ie restored");
    add_row(OP_WR, MIP_ADDR, 32'h0, idle, 0, "software clears mip");
    add_row(OP_RD, MIP_ADDR, 0, idle, 0, "mip is clear");
    add_row(OP_WR, MCAUSE_ADDR, 32'h2, build_trap(F_MALINSN, epc_c, 32'h0), 0,
            "write against trap");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'd0, "trap value kept in mcause");
    add_row(OP_RD, MEPC_ADDR, 0, idle, epc_c, "mepc from trap");
    add_row(OP_RD, 8'h1C, 0, idle, 0, "unmapped read");
    add_row(OP_WR, 8'h1C, 32'hFFFF_FFFF, idle, 0, "unmapped write");
    add_row(OP_RD, 8'h02, 0, idle, 0, "misaligned read");
    add_row(OP_WR, 8'h40, 32'hFFFF_FFFF, idle, 0, "out of range write");
    add_row(OP_RD, MSTATUS_ADDR, 0, idle, 0, "mstatus unchanged");
    add_row(OP_RD, MIE_ADDR, 0, idle, 0, "mie unchanged");
    add_row(OP_RD, MTVEC_ADDR, 0, idle, 32'h100, "mtvec unchanged");
    add_row(OP_RD, MEPC_ADDR, 0, idle, epc_c, "mepc unchanged");
    add_row(OP_RD, MCAUSE_ADDR, 0, idle, 32'd0, "mcause unchanged");
    add_row(OP_RD, MBADADDR_ADDR, 0, idle, 32'h0, "mbadaddr unchanged");
    add_row(OP_RD, MIP_ADDR, 0, idle, 0, "mip unchanged");
  endtask

  // Watchdog sized from the table with four cycles per row plus reset
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = rows.size() * 4 * 40 + 8 * 40;
    #(limit_ns);
    $display("Timeout after %0d ns, the test table did not complete", limit_ns);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    row_t r;
    apb_req  <= '0;
    trap_req <= '0;
    rst      <= 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_signal("trap_vector", trap_vector, 32'h100);
    compare_signal("intr", {31'b0, intr}, 32'h0);
    compare_signal("pready", {31'b0, apb_rsp.pready}, 32'h0);
    $display("%s: reset outputs", (row_errs == 0) ? "passed" : "failed");
    err_count += row_errs;
    if (row_errs != 0) fail_rows++;
    for (int i = 0; i < rows.size(); i++) begin
      r        = rows[i];
      row_errs = 0;
      @(posedge clk); // Setup phase where the previous trap is withdrawn
      apb_req.psel    <= (r.op != OP_NONE);
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= (r.op == OP_WR);
      apb_req.paddr   <= {24'b0, r.addr};
      apb_req.pwdata  <= r.wdata;
      trap_req        <= '0;
      @(posedge clk); // Access phase with this row's trap
      apb_req.penable <= (r.op != OP_NONE);
      trap_req        <= r.trap;
      @(negedge clk);
      compare_signal("intr", {31'b0, intr}, {31'b0, r.exp_intr});
      compare_signal("pready", {31'b0, apb_rsp.pready}, {31'b0, (r.op != OP_NONE)});
      if (r.op != OP_NONE) begin
        compare_signal("pslverr", {31'b0, apb_rsp.pslverr}, {31'b0, r.exp_err});
      end
      if (r.op == OP_RD) compare_signal("prdata", apb_rsp.prdata, r.exp_data);
      $display("%s: %s", (row_errs == 0) ? "passed" : "failed", names[i]);
      err_count += row_errs;
      if (row_errs != 0) fail_rows++;
    end
    @(posedge clk);
    apb_req  <= '0;
    trap_req <= '0;
    @(negedge clk);
    $display("%0d tests, %0d failed, %0d mismatches", rows.size() + 1, fail_rows, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
machine_mode_pkg.sv
prv_control.sv
csr_machine.sv
csr_apb_slave.sv
priv_unit_top.sv
tb_priv_unit.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_priv_unit -f all.f -o sim_priv_unit

# The log decides the result, so a non-zero simulator exit must not stop the script here
./obj_dir/sim_priv_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
